// File: common/cpu_pkg.sv
package cpu_pkg;

  localparam int WORD_W  = 32;
  localparam int CLASS_W = 4;
  localparam int OP_W    = 4;
  localparam int SPU_W   = 2;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [WORD_W-1:0]  ir_t;
  typedef logic [CLASS_W-1:0] ir_class_t;
  typedef logic [OP_W-1:0]    ir_op_t;
  typedef logic [SPU_W-1:0]   sp_upd_t;

  // instruction word fields
  localparam int IR_CLASS_HI = 31;
  localparam int IR_CLASS_LO = 28;
  localparam int IR_OP_HI    = 27;
  localparam int IR_OP_LO    = 24;

  localparam ir_class_t CL_INH   = 4'h0; // inhibited, trap
  localparam ir_class_t CL_PUSH  = 4'h1; // op 0 push, else jsr
  localparam ir_class_t CL_POP   = 4'h2; // op 0 pop, else rts
  localparam ir_class_t CL_LOAD  = 4'h3;
  localparam ir_class_t CL_STORE = 4'h4;

  localparam ir_op_t TRAP_OP = 4'h5; // software exception

  localparam sp_upd_t SP_NONE = 2'h0;
  localparam sp_upd_t SP_INC  = 2'h1; // pop, rts
  localparam sp_upd_t SP_DEC  = 2'h2; // push, jsr, exception

  // one stack slot
  localparam word_t STACK_STEP = 32'h0000_0004;

  localparam word_t RESET_SP   = 32'h0000_0400;
  localparam word_t EXC_VECTOR = 32'h0000_0100;

endpackage

// File: common/bus_pkg.sv
package bus_pkg;

  localparam int ADR_W  = 32;
  localparam int DAT_W  = 32;
  localparam int SEL_W  = DAT_W / 8;
  localparam int SIZE_W = 2;

  typedef logic [ADR_W-1:0]  adr_t;
  typedef logic [DAT_W-1:0]  dat_t;
  typedef logic [SEL_W-1:0]  sel_t;
  typedef logic [SIZE_W-1:0] size_t;

  localparam size_t SZ_WORD = 2'h0;
  localparam size_t SZ_HALF = 2'h1;
  localparam size_t SZ_BYTE = 2'h2;

  // big-endian lanes, offset 0 in lane 3
  localparam sel_t SEL_WORD    = 4'hf;
  localparam sel_t SEL_HALF_HI = 4'b1100;
  localparam sel_t SEL_HALF_LO = 4'b0011;
  localparam sel_t SEL_BYTE_0  = 4'b1000;
  localparam sel_t SEL_BYTE_1  = 4'b0100;
  localparam sel_t SEL_BYTE_2  = 4'b0010;
  localparam sel_t SEL_BYTE_3  = 4'b0001;

endpackage

// File: common/wb_if.sv
`timescale 1ns/1ps

interface wb_if;
  import bus_pkg::*;

  logic cyc;
  logic stb;
  logic we;
  adr_t adr;
  sel_t sel;
  dat_t dat_m; // master to slave
  logic ack;
  dat_t dat_s; // slave to master

  modport master (
    output cyc, stb, we, adr, sel, dat_m,
    input  ack, dat_s
  );

  modport slave (
    input  cyc, stb, we, adr, sel, dat_m,
    output ack, dat_s
  );

endinterface

// File: common/retire_if.sv
`timescale 1ns/1ps

interface retire_if;
  import cpu_pkg::*;

  logic    valid;
  word_t   result;
  word_t   pc;
  logic    pc_set; // pc is a redirect target
  sp_upd_t sp_upd;

  modport src (
    output valid, result, pc, pc_set, sp_upd
  );

  modport dst (
    input valid, result, pc, pc_set, sp_upd
  );

endinterface

// File: mem/lane_steer.sv
`timescale 1ns/1ps

module lane_steer (
  input  bus_pkg::size_t size_i,
  input  bus_pkg::adr_t  adr_i,
  input  cpu_pkg::word_t wdata_i,
  output bus_pkg::sel_t  sel_o,
  output cpu_pkg::word_t wdata_o,
  input  bus_pkg::sel_t  rsel_i,
  input  cpu_pkg::word_t rdata_i,
  output cpu_pkg::word_t rdata_o
);
  import cpu_pkg::*;
  import bus_pkg::*;

  // select and store data placement
  always_comb
  begin
    case (size_i)
      SZ_HALF:
      begin
        sel_o   = adr_i[1] ? SEL_HALF_LO : SEL_HALF_HI;
        wdata_o = {2{wdata_i[15:0]}};
      end
      SZ_BYTE:
      begin
        sel_o   = SEL_BYTE_0 >> adr_i[1:0]; // lane 3 - offset
        wdata_o = {4{wdata_i[7:0]}};
      end
      default:
      begin
        sel_o   = SEL_WORD;
        wdata_o = wdata_i;
      end
    endcase
  end

  // load extraction follows the select on the bus
  always_comb
  begin
    case (rsel_i)
      SEL_HALF_HI: rdata_o = {16'h0, rdata_i[31:16]};
      SEL_HALF_LO: rdata_o = {16'h0, rdata_i[15:0]};
      SEL_BYTE_0:  rdata_o = {24'h0, rdata_i[31:24]};
      SEL_BYTE_1:  rdata_o = {24'h0, rdata_i[23:16]};
      SEL_BYTE_2:  rdata_o = {24'h0, rdata_i[15:8]};
      SEL_BYTE_3:  rdata_o = {24'h0, rdata_i[7:0]};
      default:     rdata_o = rdata_i;
    endcase
  end

endmodule

// File: mem/mem_access.sv
`timescale 1ns/1ps

module mem_access #(
  parameter cpu_pkg::word_t EXC_VECTOR = cpu_pkg::EXC_VECTOR
) (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           op_valid_i,
  input  cpu_pkg::ir_t   ir_i,
  input  cpu_pkg::word_t addr_i,
  input  cpu_pkg::word_t store_data_i,
  input  cpu_pkg::word_t pc_i,
  input  cpu_pkg::word_t sp_i,
  input  logic           exc_i,
  output logic           busy_o,
  output bus_pkg::size_t steer_size_o,
  output bus_pkg::adr_t  steer_adr_o,
  input  bus_pkg::sel_t  steer_sel_i,
  input  cpu_pkg::word_t steer_wdata_i,
  input  cpu_pkg::word_t load_data_i,
  wb_if.master           bus,
  retire_if.src          ret
);
  import cpu_pkg::*;
  import bus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_STORE,
    ST_PUSH,
    ST_POP,
    ST_JSR,
    ST_RTS,
    ST_EXC
  } state_t;

  state_t    state;
  state_t    start_state;
  ir_class_t cls;
  ir_op_t    op;
  logic      issue;
  logic      done;
  logic      start_bus;
  logic      start_we;
  adr_t      start_adr;
  sel_t      start_sel;
  word_t     start_dat;
  word_t     start_pc;
  word_t     end_result;
  logic      end_pc_set;
  sp_upd_t   end_sp_upd;

  assign cls   = ir_i[IR_CLASS_HI:IR_CLASS_LO];
  assign op    = ir_i[IR_OP_HI:IR_OP_LO];
  assign issue = op_valid_i && (state == ST_IDLE);
  assign done  = (state != ST_IDLE) && bus.ack;

  assign busy_o       = bus.cyc;
  assign steer_size_o = size_t'(op[1:0]);
  assign steer_adr_o  = addr_i;

  // decode of the issued operation
  always_comb
  begin
    start_state = ST_IDLE;
    start_bus   = 1'b0;
    start_we    = 1'b0;
    start_adr   = sp_i - STACK_STEP; // predecrement for stack writes
    start_sel   = SEL_WORD;
    start_dat   = store_data_i;
    start_pc    = pc_i;
    if (exc_i)
    begin
      start_state = ST_EXC;
      start_bus   = 1'b1;
      start_we    = 1'b1;
      start_dat   = pc_i - STACK_STEP; // retry interrupted instruction
      start_pc    = EXC_VECTOR;
    end
    else
    begin
      case (cls)
        CL_INH:
          if (op == TRAP_OP)
          begin
            start_state = ST_EXC;
            start_bus   = 1'b1;
            start_we    = 1'b1;
            start_dat   = pc_i;
            start_pc    = EXC_VECTOR;
          end
        CL_LOAD, CL_STORE:
        begin
          start_state = (cls == CL_LOAD) ? ST_LOAD : ST_STORE;
          start_bus   = 1'b1;
          start_we    = (cls == CL_STORE);
          start_adr   = addr_i;
          start_sel   = steer_sel_i;
          start_dat   = steer_wdata_i;
        end
        CL_PUSH:
        begin
          start_bus = 1'b1;
          start_we  = 1'b1;
          if (op == '0)
            start_state = ST_PUSH;
          else
          begin
            start_state = ST_JSR;
            start_dat   = pc_i; // return address
            start_pc    = addr_i;
          end
        end
        CL_POP:
        begin
          start_state = (op == '0) ? ST_POP : ST_RTS;
          start_bus   = 1'b1;
          start_adr   = sp_i;
        end
        default:
        begin
        end
      endcase
    end
  end

  // retire record at the end of the bus cycle
  always_comb
  begin
    end_result = '0;
    end_pc_set = 1'b0;
    end_sp_upd = SP_NONE;
    case (state)
      ST_LOAD:
        end_result = load_data_i;
      ST_PUSH:
        end_sp_upd = SP_DEC;
      ST_POP:
      begin
        end_result = bus.dat_s;
        end_sp_upd = SP_INC;
      end
      ST_JSR, ST_EXC:
      begin
        end_pc_set = 1'b1;
        end_sp_upd = SP_DEC;
      end
      ST_RTS:
      begin
        end_pc_set = 1'b1;
        end_sp_upd = SP_INC;
      end
      default:
      begin
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state      <= ST_IDLE;
      bus.cyc    <= 1'b0;
      bus.stb    <= 1'b0;
      bus.we     <= 1'b0;
      ret.valid  <= 1'b0;
      ret.pc_set <= 1'b0;
      ret.sp_upd <= SP_NONE;
    end
    else
    begin
      bus.stb    <= 1'b0; // first cycle only
      ret.valid  <= 1'b0;
      ret.pc_set <= 1'b0;
      ret.sp_upd <= SP_NONE;
      if (issue)
      begin
        if (start_bus)
        begin
          state   <= start_state;
          bus.cyc <= 1'b1;
          bus.stb <= 1'b1;
          bus.we  <= start_we;
        end
        else
          ret.valid <= 1'b1; // no-op retires at once
      end
      else if (done)
      begin
        state      <= ST_IDLE;
        bus.cyc    <= 1'b0;
        bus.we     <= 1'b0;
        ret.valid  <= 1'b1;
        ret.pc_set <= end_pc_set;
        ret.sp_upd <= end_sp_upd;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      bus.adr    <= start_adr;
      bus.sel    <= start_sel;
      bus.dat_m  <= start_dat;
      ret.result <= '0;
      ret.pc     <= start_pc;
    end
    else if (done)
    begin
      ret.result <= end_result;
      if (state == ST_RTS)
        ret.pc <= bus.dat_s; // popped return address
    end
  end

  a_no_issue_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    op_valid_i |-> !busy_o);

  a_stb_single: assert property (@(posedge clk_i) disable iff (rst_i)
    bus.stb |-> bus.cyc ##1 !bus.stb);

  a_cyc_after_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(bus.cyc) |-> $past(bus.ack));

endmodule

// File: hdl/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int RAM_WORDS   = 256,
  parameter int WAIT_STATES = 1
) (
  input  logic clk_i,
  input  logic rst_i,
  wb_if.slave  bus
);
  import bus_pkg::*;

  localparam int AW = $clog2(RAM_WORDS);
  localparam int CW = $clog2(WAIT_STATES + 2);

  dat_t          mem [RAM_WORDS];
  logic [AW-1:0] idx;
  logic [CW-1:0] cnt;
  logic          start;
  logic          fire;

  assign idx   = bus.adr[AW+1:2]; // word index
  assign start = bus.cyc && bus.stb;
  assign fire  = (WAIT_STATES == 0) ? start : (cnt == CW'(1));

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      cnt     <= '0;
      bus.ack <= 1'b0;
    end
    else
    begin
      bus.ack <= fire;
      if (start)
        cnt <= CW'(WAIT_STATES);
      else if (cnt != '0)
        cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start && bus.we)
    begin
      for (int i = 0; i < SEL_W; i++)
        if (bus.sel[i])
          mem[idx][i*8 +: 8] <= bus.dat_m[i*8 +: 8]; // lane 3 is msb
    end
    if (fire)
      bus.dat_s <= mem[idx];
  end

  a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    bus.ack |-> bus.cyc);

endmodule

// File: hdl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage #(
  parameter cpu_pkg::word_t RESET_SP = cpu_pkg::RESET_SP
) (
  input  logic           clk_i,
  input  logic           rst_i,
  retire_if.dst          ret,
  output cpu_pkg::word_t sp_o,
  output logic           retire_valid_o,
  output logic           pc_set_o,
  output cpu_pkg::word_t result_o,
  output cpu_pkg::word_t pc_o
);
  import cpu_pkg::*;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      sp_o           <= RESET_SP;
      retire_valid_o <= 1'b0;
      pc_set_o       <= 1'b0;
    end
    else
    begin
      retire_valid_o <= ret.valid;
      pc_set_o       <= ret.valid && ret.pc_set;
      if (ret.valid)
      begin
        case (ret.sp_upd)
          SP_INC:  sp_o <= sp_o + STACK_STEP;
          SP_DEC:  sp_o <= sp_o - STACK_STEP;
          default: sp_o <= sp_o;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (ret.valid)
    begin
      result_o <= ret.result;
      pc_o     <= ret.pc;
    end
  end

endmodule

// File: hdl/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys #(
  parameter int             RAM_WORDS   = 256,
  parameter int             WAIT_STATES = 1,
  parameter cpu_pkg::word_t RESET_SP    = cpu_pkg::RESET_SP,
  parameter cpu_pkg::word_t EXC_VECTOR  = cpu_pkg::EXC_VECTOR
) (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           op_valid_i,
  input  cpu_pkg::ir_t   ir_i,
  input  cpu_pkg::word_t addr_i,
  input  cpu_pkg::word_t store_data_i,
  input  cpu_pkg::word_t pc_i,
  input  logic           exc_i,
  output logic           busy_o,
  output logic           retire_valid_o,
  output cpu_pkg::word_t result_o,
  output cpu_pkg::word_t pc_o,
  output logic           pc_set_o,
  output cpu_pkg::word_t sp_o
);
  import cpu_pkg::*;
  import bus_pkg::*;

  size_t steer_size;
  adr_t  steer_adr;
  sel_t  steer_sel;
  word_t steer_wdata;
  word_t load_data;

  wb_if     wb ();
  retire_if ret ();

  mem_access #(
    .EXC_VECTOR(EXC_VECTOR)
  ) i_mem_access (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .op_valid_i   (op_valid_i),
    .ir_i         (ir_i),
    .addr_i       (addr_i),
    .store_data_i (store_data_i),
    .pc_i         (pc_i),
    .sp_i         (sp_o), // stack pointer from writeback
    .exc_i        (exc_i),
    .busy_o       (busy_o),
    .steer_size_o (steer_size),
    .steer_adr_o  (steer_adr),
    .steer_sel_i  (steer_sel),
    .steer_wdata_i(steer_wdata),
    .load_data_i  (load_data),
    .bus          (wb.master),
    .ret          (ret.src)
  );

  lane_steer i_lane_steer (
    .size_i (steer_size),
    .adr_i  (steer_adr),
    .wdata_i(store_data_i),
    .sel_o  (steer_sel),
    .wdata_o(steer_wdata),
    .rsel_i (wb.sel),
    .rdata_i(wb.dat_s),
    .rdata_o(load_data)
  );

  data_ram #(
    .RAM_WORDS  (RAM_WORDS),
    .WAIT_STATES(WAIT_STATES)
  ) i_data_ram (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .bus  (wb.slave)
  );

  writeback_stage #(
    .RESET_SP(RESET_SP)
  ) i_writeback_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ret           (ret.dst),
    .sp_o          (sp_o),
    .retire_valid_o(retire_valid_o),
    .pc_set_o      (pc_set_o),
    .result_o      (result_o),
    .pc_o          (pc_o)
  );

endmodule

// File: tests/mem_tests.svh
`ifndef MEM_TESTS_SVH
`define MEM_TESTS_SVH

function automatic word_t make_ir(input ir_class_t cls, input ir_op_t op);
  return {cls, op, 24'h0};
endfunction

// one operation from issue strobe to retire strobe
task automatic issue_op(input word_t op_ir, input word_t op_addr, input word_t op_data,
                        input word_t op_pc, input logic op_exc);
  int waited;
  waited      = 0;
  busy_cycles = 0;
  idle_cycles = 0;
  @(negedge clk);
  op_valid   = 1'b1;
  ir         = op_ir;
  addr       = op_addr;
  store_data = op_data;
  pc         = op_pc;
  exc        = op_exc;
  @(negedge clk);
  op_valid   = 1'b0;
  exc        = 1'b0;
  busy_first = busy;
  while (!retire_valid && waited < OP_TIMEOUT)
  begin
    if (busy)
      busy_cycles++;
    else
      idle_cycles++;
    @(negedge clk);
    waited++;
  end
  if (!retire_valid)
  begin
    errors++;
    $display("operation with ir %h was issued but never retired", op_ir);
  end
  busy_at_retire = busy;
  got_result     = result;
  got_pc         = pc_out;
  got_pc_set     = pc_set;
  got_sp         = sp;
endtask

// big-endian, offset 0 is the top byte
task automatic model_store(input word_t a, input word_t d, input size_t size);
  logic [9:0] w;
  w = {a[9:2], 2'b00};
  case (size)
    SZ_HALF:
    begin
      shadow[{a[9:1], 1'b0}] = d[15:8];
      shadow[{a[9:1], 1'b1}] = d[7:0];
    end
    SZ_BYTE:
      shadow[a[9:0]] = d[7:0];
    default:
    begin
      shadow[w]         = d[31:24];
      shadow[w + 10'd1] = d[23:16];
      shadow[w + 10'd2] = d[15:8];
      shadow[w + 10'd3] = d[7:0];
    end
  endcase
endtask

function automatic word_t expected_load(input word_t a, input size_t size);
  logic [9:0] w;
  logic [9:0] h;
  w = {a[9:2], 2'b00};
  h = {a[9:1], 1'b0};
  case (size)
    SZ_HALF: return {16'h0, shadow[h], shadow[h + 10'd1]};
    SZ_BYTE: return {24'h0, shadow[a[9:0]]};
    default: return {shadow[w], shadow[w + 10'd1], shadow[w + 10'd2], shadow[w + 10'd3]};
  endcase
endfunction

task automatic store_mem(input word_t a, input word_t d, input size_t size);
  issue_op(make_ir(CL_STORE, {2'b00, size}), a, d, 32'h0000_2000, 1'b0);
  model_store(a, d, size);
  check_value("pc_set_o", 32'h0, {31'h0, got_pc_set});
endtask

task automatic load_check(input word_t a, input size_t size);
  issue_op(make_ir(CL_LOAD, {2'b00, size}), a, 32'h0, 32'h0000_2000, 1'b0);
  check_value("result_o", expected_load(a, size), got_result);
endtask

task automatic push_word(input word_t d);
  issue_op(make_ir(CL_PUSH, 4'h0), 32'h0, d, 32'h0000_2000, 1'b0);
  exp_sp = exp_sp - 32'd4;
  model_store(exp_sp, d, SZ_WORD);
  check_value("sp_o", exp_sp, got_sp);
  check_value("pc_set_o", 32'h0, {31'h0, got_pc_set});
endtask

task automatic pop_word(input word_t expected);
  issue_op(make_ir(CL_POP, 4'h0), 32'h0, 32'h0, 32'h0000_2000, 1'b0);
  exp_sp = exp_sp + 32'd4;
  check_value("result_o", expected, got_result);
  check_value("sp_o", exp_sp, got_sp);
  check_value("pc_set_o", 32'h0, {31'h0, got_pc_set});
endtask

task automatic check_redirect(input word_t target);
  check_value("pc_set_o", 32'h1, {31'h0, got_pc_set});
  check_value("pc_o", target, got_pc);
  check_value("sp_o", exp_sp, got_sp);
endtask

task automatic check_busy_span();
  check_value("busy_o after issue", 32'h1, {31'h0, busy_first});
  check_value("busy_o at retire", 32'h0, {31'h0, busy_at_retire});
  check_value("busy_o low cycles before retire", 32'h1, idle_cycles); // writeback register
endtask

task automatic test_reset_state();
  check_value("busy_o", 32'h0, {31'h0, busy});
  check_value("retire_valid_o", 32'h0, {31'h0, retire_valid});
  check_value("pc_set_o", 32'h0, {31'h0, pc_set});
  check_value("sp_o", SP_AT_RESET, sp);
  report_test("reset state");
endtask

task automatic test_word_access();
  word_t addrs [8];
  word_t rnd;
  for (int i = 0; i < 8; i++)
  begin
    rnd      = $random(seed);
    addrs[i] = {23'h0, rnd[8:2], 2'b00}; // below the sub-word area
    store_mem(addrs[i], $random(seed), SZ_WORD);
  end
  for (int i = 0; i < 8; i++)
    load_check(addrs[i], SZ_WORD);
  report_test("word access");
endtask

task automatic test_subword_access();
  word_t rnd;
  word_t base;
  rnd  = $random(seed);
  base = {22'h0, 2'b10, rnd[7:2], 2'b00};
  store_mem(base, 32'h1122_3344, SZ_WORD);
  store_mem(base + 32'd1, 32'h0000_00aa, SZ_BYTE);
  load_check(base, SZ_WORD);
  check_value("result_o", 32'h11aa_3344, got_result); // offset 1 is lane 2
  store_mem(base, $random(seed), SZ_WORD);
  for (int off = 0; off < 4; off += 2)
  begin
    store_mem(base + off, $random(seed), SZ_HALF);
    load_check(base, SZ_WORD);
  end
  for (int off = 0; off < 4; off++)
  begin
    store_mem(base + off, $random(seed), SZ_BYTE);
    load_check(base, SZ_WORD);
  end
  for (int off = 0; off < 4; off += 2)
    load_check(base + off, SZ_HALF);
  for (int off = 0; off < 4; off++)
    load_check(base + off, SZ_BYTE);
  report_test("sub-word access");
endtask

task automatic test_push_pop();
  word_t d0;
  word_t d1;
  d0 = $random(seed);
  d1 = $random(seed);
  push_word(d0);
  load_check(exp_sp, SZ_WORD);
  check_value("stack word", d0, got_result);
  push_word(d1);
  pop_word(d1);
  pop_word(d0);
  report_test("push and pop");
endtask

task automatic test_call_return();
  word_t target;
  word_t ret_pc;
  target = $random(seed) & 32'hffff_fffc;
  ret_pc = $random(seed) & 32'hffff_fffc;
  issue_op(make_ir(CL_PUSH, 4'h1), target, $random(seed), ret_pc, 1'b0);
  exp_sp = exp_sp - 32'd4;
  model_store(exp_sp, ret_pc, SZ_WORD);
  check_redirect(target);
  load_check(exp_sp, SZ_WORD);
  issue_op(make_ir(CL_POP, 4'h1), 32'h0, 32'h0, 32'h0000_2000, 1'b0);
  exp_sp = exp_sp + 32'd4;
  check_redirect(ret_pc);
  report_test("call and return");
endtask

task automatic test_exceptions();
  word_t pc_exc;
  word_t pc_trap;
  pc_exc  = ($random(seed) & 32'h0000_fffc) + 32'd4;
  pc_trap = $random(seed) & 32'h0000_fffc;
  // request overrides the load in ir
  issue_op(make_ir(CL_LOAD, 4'h0), 32'h0000_0010, 32'h0, pc_exc, 1'b1);
  exp_sp = exp_sp - 32'd4;
  model_store(exp_sp, pc_exc - 32'd4, SZ_WORD);
  check_redirect(EXC_TARGET);
  load_check(exp_sp, SZ_WORD);
  issue_op(make_ir(CL_INH, TRAP_OP), 32'h0, 32'h0, pc_trap, 1'b0);
  exp_sp = exp_sp - 32'd4;
  model_store(exp_sp, pc_trap, SZ_WORD);
  check_redirect(EXC_TARGET);
  load_check(exp_sp, SZ_WORD);
  pop_word(pc_trap);
  pop_word(pc_exc - 32'd4);
  report_test("exceptions");
endtask

task automatic test_busy_noop();
  word_t rnd;
  word_t a;
  rnd = $random(seed);
  a   = {23'h0, rnd[8:2], 2'b00};
  store_mem(a, $random(seed), SZ_WORD);
  check_busy_span();
  load_check(a, SZ_WORD);
  check_busy_span();
  for (int n = 0; n < 2; n++)
  begin
    issue_op(make_ir(CL_INH, ir_op_t'(n * 7)), a, $random(seed), 32'h0000_3000, 1'b0);
    check_value("pc_set_o", 32'h0, {31'h0, got_pc_set});
    check_value("sp_o", exp_sp, got_sp);
    check_value("busy_o high cycles", 32'h0, busy_cycles);
    check_value("cycles before retire", 32'h1, idle_cycles);
    load_check(a, SZ_WORD); // memory untouched
  end
  report_test("busy and no-op");
endtask

`endif

// File: tests/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
  import cpu_pkg::*;
  import bus_pkg::*;

  localparam int    CLK_PERIOD  = 40;
  localparam int    NUM_TESTS   = 7;
  localparam int    OP_TIMEOUT  = 50; // cycles per operation
  localparam word_t SP_AT_RESET = 32'h0000_0400;
  localparam word_t EXC_TARGET  = 32'h0000_0100;

  logic  clk = 1'b0;
  logic  rst;
  logic  op_valid;
  word_t ir;
  word_t addr;
  word_t store_data;
  word_t pc;
  logic  exc;
  logic  busy;
  logic  retire_valid;
  word_t result;
  word_t pc_out;
  logic  pc_set;
  word_t sp;

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     errors_before;

  // captured at the retire strobe
  word_t got_result;
  word_t got_pc;
  logic  got_pc_set;
  word_t got_sp;
  logic  busy_first;
  logic  busy_at_retire;
  int    busy_cycles;
  int    idle_cycles;

  word_t      exp_sp;
  logic [7:0] shadow [1024]; // byte image of the RAM

  mem_subsys #(
    .RAM_WORDS  (256),
    .WAIT_STATES(2),
    .RESET_SP   (SP_AT_RESET),
    .EXC_VECTOR (EXC_TARGET)
  ) i_mem_subsys (
    .clk_i         (clk),
    .rst_i         (rst),
    .op_valid_i    (op_valid),
    .ir_i          (ir),
    .addr_i        (addr),
    .store_data_i  (store_data),
    .pc_i          (pc),
    .exc_i         (exc),
    .busy_o        (busy),
    .retire_valid_o(retire_valid),
    .result_o      (result),
    .pc_o          (pc_out),
    .pc_set_o      (pc_set),
    .sp_o          (sp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("test %s done with %0d errors", name, errors - errors_before);
    errors_before = errors;
  endtask

  `include "mem_tests.svh"

  initial
  begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("watchdog expired before the test sequence completed");
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    seed          = 89919;
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    errors_before = 0;
    rst           = 1'b1;
    op_valid      = 1'b0;
    ir            = '0;
    addr          = '0;
    store_data    = '0;
    pc            = '0;
    exc           = 1'b0;
    repeat (2) @(negedge clk);
    rst    = 1'b0;
    exp_sp = SP_AT_RESET;

    test_reset_state();
    test_word_access();
    test_subword_access();
    test_push_pop();
    test_call_return();
    test_exceptions();
    test_busy_noop();

    $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: sim.f
+incdir+tests
common/cpu_pkg.sv
common/bus_pkg.sv
common/wb_if.sv
common/retire_if.sv
mem/lane_steer.sv
mem/mem_access.sv
hdl/data_ram.sv
hdl/writeback_stage.sv
hdl/mem_subsys.sv
tests/tb_mem_subsys.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
  --top-module tb_mem_subsys \
  -f sim.f \
  -Mdir obj_dir

./obj_dir/Vtb_mem_subsys > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
